// File: serial_alu.sv
`timescale 1ns/1ps
`include "serial_defs.svh"

module serial_alu (
   input  logic                    i_clk,
   input  logic                    i_load,
   input  logic                    i_step,
   input  logic                    i_first,
   input  serial_pkg::alu_op_e     i_op,
   input  logic [`SERIAL_XLEN-1:0] i_rs1,
   input  logic [`SERIAL_XLEN-1:0] i_op_b,
   output logic [`SERIAL_XLEN-1:0] o_rd
);

   logic [`SERIAL_XLEN-1:0] rs1_q;
   logic [`SERIAL_XLEN-1:0] opb_q;
   logic [`SERIAL_XLEN-1:0] rd_q;
   logic                    carry_q;
   logic                    cmp_q;
   logic                    is_cmp;
   logic                    is_signed;
   logic                    is_sub;
   logic                    a;
   logic                    b;
   logic                    b_eff;
   logic                    c_in;
   logic                    c_out;
   logic                    sum;
   logic                    res_bit;

   assign is_cmp    = (i_op == serial_pkg::ALU_SLT) || (i_op == serial_pkg::ALU_SLTU);
   assign is_signed = i_op == serial_pkg::ALU_SLT;
   assign is_sub    = (i_op == serial_pkg::ALU_SUB) || is_cmp;

   // Current bit of each operand, LSB first
   assign a = rs1_q[0];
   assign b = opb_q[0];

   // Subtract as a + ~b + 1, the +1 coming from the preset carry
   assign b_eff = b ^ is_sub;
   assign c_in  = i_first ? is_sub : carry_q;
   assign sum   = a ^ b_eff ^ c_in;
   assign c_out = (a & b_eff) | (c_in & (a ^ b_eff));

   always_comb begin
      case (i_op)
         serial_pkg::ALU_AND: res_bit = a & b;
         serial_pkg::ALU_OR:  res_bit = a | b;
         serial_pkg::ALU_XOR: res_bit = a ^ b;
         default:             res_bit = sum;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         rs1_q <= i_rs1;
         opb_q <= i_op_b;
      end else if (i_step) begin
         rs1_q   <= rs1_q >> 1;
         opb_q   <= opb_q >> 1;
         rd_q    <= {res_bit, rd_q[`SERIAL_XLEN-1:1]};
         carry_q <= c_out;
         // Borrow out, sign-corrected for SLT; only the last step's value counts
         cmp_q   <= ~c_out ^ (is_signed & (a ^ b));
      end
   end

   assign o_rd = is_cmp ? {{(`SERIAL_XLEN-1){1'b0}}, cmp_q} : rd_q;

endmodule

// File: serial_core.sv
`timescale 1ns/1ps
`include "serial_defs.svh"

module serial_core (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_instr_valid,
   input  logic [`SERIAL_XLEN-1:0] i_instr,
   output logic                    o_busy,
   output logic                    o_illegal,
   output logic                    o_done,
   output serial_pkg::result_t     o_result
);

   logic                    issue;
   serial_pkg::issue_t      issue_data;
   logic                    load;
   logic                    step;
   logic                    first;
   logic                    write;
   logic [`SERIAL_XLEN-1:0] rs1;
   logic [`SERIAL_XLEN-1:0] op_b;
   logic [`SERIAL_XLEN-1:0] alu_rd;

   serial_decode decode (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_busy        (o_busy),
      .o_issue       (issue),
      .o_issue_data  (issue_data),
      .o_illegal     (o_illegal)
   );

   serial_state state (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_issue (issue),
      .o_busy  (o_busy),
      .o_load  (load),
      .o_step  (step),
      .o_first (first),
      .o_write (write)
   );

   serial_alu alu (
      .i_clk   (i_clk),
      .i_load  (load),
      .i_step  (step),
      .i_first (first),
      .i_op    (issue_data.op),
      .i_rs1   (rs1),
      .i_op_b  (op_b),
      .o_rd    (alu_rd)
   );

   serial_regfile regfile (
      .i_clk        (i_clk),
      .i_issue      (issue),
      .i_issue_data (issue_data),
      .i_write      (write),
      .i_rd_data    (alu_rd),
      .o_rs1        (rs1),
      .o_op_b       (op_b),
      .o_done       (o_done),
      .o_result     (o_result)
   );

endmodule

// File: serial_decode.sv
`timescale 1ns/1ps
`include "serial_defs.svh"

module serial_decode (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_instr_valid,
   input  logic [`SERIAL_XLEN-1:0] i_instr,
   input  logic                    i_busy,
   output logic                    o_issue,
   output serial_pkg::issue_t      o_issue_data,
   output logic                    o_illegal
);

   logic [6:0]          opcode;
   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic                accept;
   logic                is_op;
   logic                is_imm;
   logic                legal;
   serial_pkg::alu_op_e op;
   serial_pkg::issue_t  dec;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];
   assign is_op  = opcode == `SERIAL_OPC_OP;
   assign is_imm = opcode == `SERIAL_OPC_OP_IMM;

   // Strobes while busy are dropped here and nowhere else
   assign accept = i_instr_valid && !i_busy;

   always_comb begin
      legal = 1'b1;
      op    = serial_pkg::ALU_ADD;
      case (funct3)
         3'b000:  op = (is_op && i_instr[30]) ? serial_pkg::ALU_SUB : serial_pkg::ALU_ADD;
         3'b010:  op = serial_pkg::ALU_SLT;
         3'b011:  op = serial_pkg::ALU_SLTU;
         3'b100:  op = serial_pkg::ALU_XOR;
         3'b110:  op = serial_pkg::ALU_OR;
         3'b111:  op = serial_pkg::ALU_AND;
         // Shifts are not supported
         default: legal = 1'b0;
      endcase
      if (is_op) begin
         // Only SUB may set bit 30
         if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
            legal = 1'b0;
         end
      end else if (!is_imm) begin
         legal = 1'b0;
      end
   end

   always_comb begin
      dec.op      = op;
      dec.rd      = i_instr[11:7];
      dec.rs1     = i_instr[19:15];
      dec.rs2     = i_instr[24:20];
      dec.imm     = {{(`SERIAL_XLEN-12){i_instr[31]}}, i_instr[31:20]};
      dec.use_imm = is_imm;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_issue   <= 1'b0;
         o_illegal <= 1'b0;
      end else begin
         o_issue   <= accept && legal;
         o_illegal <= accept && !legal;
      end
   end

   // Held until the next legal instruction
   always_ff @(posedge i_clk) begin
      if (accept && legal) begin
         o_issue_data <= dec;
      end
   end

endmodule

// File: serial_defs.svh
`ifndef SERIAL_DEFS_SVH
`define SERIAL_DEFS_SVH

// Datapath word and register file geometry
`define SERIAL_XLEN   32
`define SERIAL_REG_AW 5

// Serial step counter, one count per bit of the word
`define SERIAL_CNT_W  5

// RV32I major opcodes handled by the unit
`define SERIAL_OPC_OP     7'b0110011
`define SERIAL_OPC_OP_IMM 7'b0010011

`endif

// File: serial_pkg.sv
`include "serial_defs.svh"

package serial_pkg;

   // ALU operation, one per supported instruction group
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_SLT  = 3'd5,
      ALU_SLTU = 3'd6
   } alu_op_e;

   // Sequencer states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_LOAD  = 2'd1,
      ST_RUN   = 2'd2,
      ST_WRITE = 2'd3
   } seq_state_e;

   // Decoded instruction handed from the decoder to the rest of the unit
   typedef struct packed {
      alu_op_e                   op;
      logic [`SERIAL_REG_AW-1:0] rd;
      logic [`SERIAL_REG_AW-1:0] rs1;
      logic [`SERIAL_REG_AW-1:0] rs2;
      logic [`SERIAL_XLEN-1:0]   imm;
      logic                      use_imm;
   } issue_t;

   // Reported write-back
   typedef struct packed {
      logic [`SERIAL_REG_AW-1:0] rd;
      logic [`SERIAL_XLEN-1:0]   data;
   } result_t;

endpackage

// File: serial_regfile.sv
`timescale 1ns/1ps
`include "serial_defs.svh"

module serial_regfile (
   input  logic                    i_clk,
   input  logic                    i_issue,
   input  serial_pkg::issue_t      i_issue_data,
   input  logic                    i_write,
   input  logic [`SERIAL_XLEN-1:0] i_rd_data,
   output logic [`SERIAL_XLEN-1:0] o_rs1,
   output logic [`SERIAL_XLEN-1:0] o_op_b,
   output logic                    o_done,
   output serial_pkg::result_t     o_result
);

   localparam int NREGS = 1 << `SERIAL_REG_AW;

   logic [`SERIAL_XLEN-1:0]   regs [0:NREGS-1];
   logic [`SERIAL_REG_AW-1:0] rd_q;
   logic [`SERIAL_XLEN-1:0]   rs2_word;

   // x0 reads as zero whatever the array holds
   assign o_rs1 = (i_issue_data.rs1 == '0) ? '0 : regs[i_issue_data.rs1];
   assign rs2_word = (i_issue_data.rs2 == '0) ? '0 : regs[i_issue_data.rs2];

   assign o_op_b = i_issue_data.use_imm ? i_issue_data.imm : rs2_word;

   always_ff @(posedge i_clk) begin
      if (i_issue) begin
         rd_q <= i_issue_data.rd;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_write && rd_q != '0) begin
         regs[rd_q] <= i_rd_data;
      end
   end

   // Report every write-back, x0 included
   assign o_done        = i_write;
   assign o_result.rd   = rd_q;
   assign o_result.data = i_rd_data;

   // Once the decoder is out of reset the sequencer's write strobe is defined
   a_write_known : assert property (
      @(posedge i_clk)
      !$isunknown(i_issue) |-> !$isunknown(i_write)
   );

   a_addr_known : assert property (
      @(posedge i_clk)
      i_issue |-> !$isunknown({i_issue_data.rs1, i_issue_data.rs2, i_issue_data.rd})
   );

endmodule

// File: serial_state.sv
`timescale 1ns/1ps
`include "serial_defs.svh"

module serial_state (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_issue,
   output logic o_busy,
   output logic o_load,
   output logic o_step,
   output logic o_first,
   output logic o_write
);

   serial_pkg::seq_state_e  st_q;
   serial_pkg::seq_state_e  st_cur;
   logic [`SERIAL_CNT_W-1:0] cnt_q;

   // The issue cycle itself is the load cycle
   assign st_cur = (st_q == serial_pkg::ST_IDLE && i_issue) ? serial_pkg::ST_LOAD : st_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         st_q  <= serial_pkg::ST_IDLE;
         cnt_q <= '0;
      end else begin
         case (st_cur)
            serial_pkg::ST_LOAD: begin
               st_q  <= serial_pkg::ST_RUN;
               cnt_q <= '0;
            end
            serial_pkg::ST_RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == '1) begin
                  st_q <= serial_pkg::ST_WRITE;
               end
            end
            serial_pkg::ST_WRITE: st_q <= serial_pkg::ST_IDLE;
            default: ;
         endcase
      end
   end

   assign o_busy  = st_cur != serial_pkg::ST_IDLE;
   assign o_load  = st_cur == serial_pkg::ST_LOAD;
   assign o_step  = st_cur == serial_pkg::ST_RUN;
   assign o_first = o_step && cnt_q == '0;
   assign o_write = st_cur == serial_pkg::ST_WRITE;

   // Decoder must hold off while a word is in flight
   a_issue_idle : assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_issue |-> st_q == serial_pkg::ST_IDLE
   );

endmodule

// File: sources.f
+incdir+.
serial_pkg.sv
serial_decode.sv
serial_state.sv
serial_alu.sv
serial_regfile.sv
serial_core.sv
tb_serial_core.sv

// File: tb_serial_vectors.svh
`ifndef TB_SERIAL_VECTORS_SVH
`define TB_SERIAL_VECTORS_SVH

// Columns: instruction word, illegal flag, expected rd, expected data
// Illegal rows carry rd and data of zero, which are not compared
localparam int NUM_VEC = 30;

localparam vec_t VEC_TABLE [NUM_VEC] = '{
   // Registers loaded from x0
   '{{12'h123, 5'd0, 3'b000, 5'd1, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd1, 32'h0000_0123},
   '{{12'hFFB, 5'd0, 3'b000, 5'd2, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd2, 32'hFFFF_FFFB},
   '{{12'h7FF, 5'd0, 3'b000, 5'd3, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd3, 32'h0000_07FF},
   '{{12'h800, 5'd0, 3'b000, 5'd4, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd4, 32'hFFFF_F800},
   // Register-register arithmetic and logic
   '{{7'h00, 5'd2, 5'd1, 3'b000, 5'd5, `SERIAL_OPC_OP}, 1'b0, 5'd5, 32'h0000_011E},
   '{{7'h20, 5'd3, 5'd1, 3'b000, 5'd6, `SERIAL_OPC_OP}, 1'b0, 5'd6, 32'hFFFF_F924},
   '{{7'h00, 5'd4, 5'd2, 3'b111, 5'd7, `SERIAL_OPC_OP}, 1'b0, 5'd7, 32'hFFFF_F800},
   '{{7'h00, 5'd3, 5'd1, 3'b110, 5'd8, `SERIAL_OPC_OP}, 1'b0, 5'd8, 32'h0000_07FF},
   '{{7'h00, 5'd2, 5'd1, 3'b100, 5'd9, `SERIAL_OPC_OP}, 1'b0, 5'd9, 32'hFFFF_FED8},
   '{{7'h00, 5'd4, 5'd2, 3'b000, 5'd10, `SERIAL_OPC_OP}, 1'b0, 5'd10, 32'hFFFF_F7FB},
   '{{7'h20, 5'd1, 5'd0, 3'b000, 5'd11, `SERIAL_OPC_OP}, 1'b0, 5'd11, 32'hFFFF_FEDD},
   // Signed and unsigned compares
   '{{7'h00, 5'd1, 5'd2, 3'b010, 5'd12, `SERIAL_OPC_OP}, 1'b0, 5'd12, 32'h0000_0001},
   '{{7'h00, 5'd1, 5'd2, 3'b011, 5'd13, `SERIAL_OPC_OP}, 1'b0, 5'd13, 32'h0000_0000},
   '{{7'h00, 5'd4, 5'd1, 3'b010, 5'd14, `SERIAL_OPC_OP}, 1'b0, 5'd14, 32'h0000_0000},
   '{{7'h00, 5'd4, 5'd1, 3'b011, 5'd15, `SERIAL_OPC_OP}, 1'b0, 5'd15, 32'h0000_0001},
   '{{12'hFFC, 5'd2, 3'b010, 5'd16, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd16, 32'h0000_0001},
   '{{12'hFFF, 5'd1, 3'b011, 5'd17, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd17, 32'h0000_0001},
   '{{12'h005, 5'd2, 3'b011, 5'd18, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd18, 32'h0000_0000},
   '{{7'h00, 5'd1, 5'd1, 3'b010, 5'd19, `SERIAL_OPC_OP}, 1'b0, 5'd19, 32'h0000_0000},
   '{{12'h800, 5'd4, 3'b010, 5'd20, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd20, 32'h0000_0000},
   // Immediate logic
   '{{12'h0F0, 5'd2, 3'b111, 5'd21, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd21, 32'h0000_00F0},
   '{{12'hF00, 5'd1, 3'b110, 5'd22, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd22, 32'hFFFF_FF23},
   '{{12'hFFF, 5'd3, 3'b100, 5'd23, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd23, 32'hFFFF_F800},
   // Write to x0 is reported, then x0 still reads zero
   '{{12'h055, 5'd1, 3'b000, 5'd0, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd0, 32'h0000_0178},
   '{{7'h00, 5'd0, 5'd1, 3'b000, 5'd24, `SERIAL_OPC_OP}, 1'b0, 5'd24, 32'h0000_0123},
   // SLLI, LUI and MUL aimed at x1 and x5
   '{{12'h001, 5'd1, 3'b001, 5'd1, `SERIAL_OPC_OP_IMM}, 1'b1, 5'd0, 32'h0000_0000},
   '{{20'hABCDE, 5'd5, 7'b0110111}, 1'b1, 5'd0, 32'h0000_0000},
   '{{7'h01, 5'd2, 5'd1, 3'b000, 5'd1, `SERIAL_OPC_OP}, 1'b1, 5'd0, 32'h0000_0000},
   '{{7'h00, 5'd5, 5'd1, 3'b000, 5'd25, `SERIAL_OPC_OP}, 1'b0, 5'd25, 32'h0000_0241},
   '{{12'hFFF, 5'd2, 3'b011, 5'd26, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd26, 32'h0000_0001}
};

`endif

// File: tb_serial_core.sv
`timescale 1ns/1ps
`include "serial_defs.svh"

module tb_serial_core;

   typedef struct packed {
      logic [`SERIAL_XLEN-1:0]   instr;
      logic                      illegal;
      logic [`SERIAL_REG_AW-1:0] rd;
      logic [`SERIAL_XLEN-1:0]   data;
   } vec_t;

   `include "tb_serial_vectors.svh"

   localparam int NUM_RAND        = 48;
   localparam int NUM_INSTR       = NUM_VEC + 31 + NUM_RAND + 3;
   localparam int WATCHDOG_CYCLES = NUM_INSTR * 40 + 200;

   // ADDI x1, x0, 0x3C3 sent while the unit is busy
   localparam logic [31:0] INTRUDER = {12'h3C3, 5'd0, 3'b000, 5'd1, `SERIAL_OPC_OP_IMM};

   logic                i_clk;
   logic                i_rst;
   logic                i_instr_valid;
   logic [31:0]         i_instr;
   logic                o_busy;
   logic                o_illegal;
   logic                o_done;
   serial_pkg::result_t o_result;

   logic [31:0] mirror [0:31];
   integer      seed;

   serial_core UUT (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_busy        (o_busy),
      .o_illegal     (o_illegal),
      .o_done        (o_done),
      .o_result      (o_result)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   task automatic report_error(input string msg);
      $display("** Error at %0d ns: %s", $time, msg);
      $display("TB FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic quiet_check(input int cycles);
      repeat (cycles) begin
         @(negedge i_clk);
         assert (!o_done && !o_illegal && !o_busy)
         else report_error("o_done, o_illegal or o_busy seen with no accepted strobe");
      end
   endtask

   // Issues one word and returns at the cycle of o_done or o_illegal
   task automatic run_instr(input logic [31:0] word, input logic inject,
                            output logic ill, output serial_pkg::result_t res);
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      ill    = 1'b0;
      @(posedge i_clk);
      i_instr_valid <= 1'b1;
      i_instr       <= word;
      while (!done && !ill) begin
         @(posedge i_clk);
         cycles++;
         i_instr_valid <= inject && cycles == 9;
         i_instr       <= (inject && cycles == 9) ? INTRUDER : word;
         @(negedge i_clk);
         done = o_done;
         ill  = o_illegal;
         res  = o_result;
         assert ((ill || o_busy) && cycles <= 34)
         else report_error($sformatf("instr %h: o_busy low or no o_done in cycle %0d",
                                     word, cycles));
      end
      if (ill) begin
         assert (cycles == 1 && !o_busy)
         else report_error($sformatf("instr %h: o_illegal late or with o_busy", word));
      end else begin
         assert (cycles == 34)
         else report_error($sformatf("instr %h: o_done after %0d cycles", word, cycles));
      end
   endtask

   task automatic expect_instr(input logic [31:0] word, input logic exp_ill,
                               input logic [4:0] exp_rd, input logic [31:0] exp_data,
                               input logic inject);
      logic                ill;
      serial_pkg::result_t res;
      run_instr(word, inject, ill, res);
      assert (ill == exp_ill)
      else report_error($sformatf("instr %h: o_illegal %0b, expected %0b", word, ill, exp_ill));
      if (!exp_ill) begin
         assert (res.rd == exp_rd && res.data === exp_data)
         else report_error($sformatf("instr %h: rd %0d data %h, expected rd %0d data %h",
                                     word, res.rd, res.data, exp_rd, exp_data));
         if (exp_rd != 0) begin
            mirror[exp_rd] = exp_data;
         end
      end
      if (exp_ill || inject) begin
         quiet_check(36);
      end
   endtask

   // Base ops 0..6 are ADD, SUB, AND, OR, XOR, SLT, SLTU
   function automatic logic [31:0] encode(input int base, input logic use_imm,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
      logic [2:0] f3;
      case (base)
         2:       f3 = 3'b111;
         3:       f3 = 3'b110;
         4:       f3 = 3'b100;
         5:       f3 = 3'b010;
         6:       f3 = 3'b011;
         default: f3 = 3'b000;
      endcase
      if (use_imm) begin
         return {imm, rs1, f3, rd, `SERIAL_OPC_OP_IMM};
      end
      return {(base == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, `SERIAL_OPC_OP};
   endfunction

   function automatic logic [31:0] model(input int base, input logic [31:0] a,
                                         input logic [31:0] b);
      case (base)
         0:       return a + b;
         1:       return a - b;
         2:       return a & b;
         3:       return a | b;
         4:       return a ^ b;
         5:       return {31'd0, $signed(a) < $signed(b)};
         default: return {31'd0, a < b};
      endcase
   endfunction

   initial begin
      int          base;
      logic [31:0] rnd;
      logic [31:0] op_b;
      logic [11:0] imm;
      seed          = 32'hb05a77cc;
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      mirror[0]     = '0;
      repeat (8) @(posedge i_clk);
      i_rst <= 1'b0;
      @(negedge i_clk);
      assert (!o_busy && !o_illegal && !o_done)
      else report_error("outputs not idle after reset");

      for (int i = 0; i < NUM_VEC; i++) begin
         expect_instr(VEC_TABLE[i].instr, VEC_TABLE[i].illegal, VEC_TABLE[i].rd,
                      VEC_TABLE[i].data, 1'b0);
      end

      // Second strobe mid-run must leave x1 alone
      expect_instr({12'h0AA, 5'd0, 3'b000, 5'd28, `SERIAL_OPC_OP_IMM}, 1'b0, 5'd28,
                   32'h0000_00AA, 1'b1);
      expect_instr({7'h00, 5'd0, 5'd1, 3'b000, 5'd29, `SERIAL_OPC_OP}, 1'b0, 5'd29,
                   mirror[1], 1'b0);

      for (int r = 1; r < 32; r++) begin
         imm = $random(seed);
         expect_instr({imm, 5'd0, 3'b000, r[4:0], `SERIAL_OPC_OP_IMM}, 1'b0, r[4:0],
                      {{20{imm[11]}}, imm}, 1'b0);
      end

      for (int n = 0; n < NUM_RAND; n++) begin
         base = {$random(seed)} % 7;
         rnd  = $random(seed);
         // No SUBI, so that draw falls back to ADDI
         if (rnd[0] && base == 1) begin
            base = 0;
         end
         op_b = rnd[0] ? {{20{rnd[27]}}, rnd[27:16]} : mirror[rnd[15:11]];
         expect_instr(encode(base, rnd[0], rnd[5:1], rnd[10:6], rnd[15:11], rnd[27:16]),
                      1'b0, rnd[5:1], model(base, mirror[rnd[10:6]], op_b), 1'b0);
      end

      $display("TB PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge i_clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule
